// File: Bender.yml
package:
  name: axi_trace

sources:
  - rtl/axi_pkg.sv
  - rtl/trace_pkg.sv
  - rtl/axi_chan_tap.sv
  - rtl/trace_arbiter.sv
  - rtl/axi_trace_top.sv
  - target: test
    files:
      - tb/tb_axi_trace_checks.sv
      - tb/tb_axi_trace.sv

// File: rtl/axi_chan_tap.sv
`timescale 1ns/1ps

module axi_chan_tap
  import axi_pkg::*;
  import trace_pkg::*;
#(
  parameter type         payload_t = axi_ax_t,
  parameter trace_chan_e chan      = CH_AR
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic [TRACE_STAMP_W-1:0] stamp,

  // source side of the channel
  input  payload_t                 src_payload,
  input  logic                     src_valid,
  output logic                     src_ready,

  // destination side of the channel
  output payload_t                 dst_payload,
  output logic                     dst_valid,
  input  logic                     dst_ready,

  // captured record toward the arbiter
  output trace_rec_t               rec,
  output logic                     rec_valid,
  input  logic                     rec_ready
);

  logic                     full;
  logic                     buf_free;
  logic                     hs;
  logic [TRACE_STAMP_W-1:0] stamp_q;
  logic [TRACE_BODY_W-1:0]  body_q;

  // the slot counts as free in the cycle its record is taken
  assign buf_free = !full || rec_ready;

  // payload is never touched, only the handshake is gated
  assign dst_payload = src_payload;
  assign dst_valid   = src_valid && buf_free;
  assign src_ready   = dst_ready && buf_free;

  assign hs = src_valid && src_ready;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      full <= 1'b0;
    end else if (hs) begin
      full <= 1'b1;
    end else if (full && rec_ready) begin
      full <= 1'b0;
    end
  end

  // record payload, loaded on every handshake
  always_ff @(posedge clk) begin
    if (hs) begin
      stamp_q <= stamp;
      // zero extension of the shorter payloads
      body_q  <= TRACE_BODY_W'(src_payload);
    end
  end

  // the channel code is fixed per tap
  assign rec       = '{chan: chan, stamp: stamp_q, body: body_q};
  assign rec_valid = full;

  // the manager must hold its request while we stall it
  a_src_stable : assert property (
    @(posedge clk) disable iff (!resetn)
    src_valid && !src_ready |=> $stable(src_payload)
  ) else $error("%m: source payload changed while stalled");

endmodule

// File: rtl/axi_pkg.sv
package axi_pkg;

  // field widths for the traced AXI port
  localparam int AXI_ID_W   = 8;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_LEN_W  = 8;
  localparam int AXI_USER_W = 4;

  // AR and AW carry the same set of fields
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    // beats minus one
    logic [AXI_LEN_W-1:0]  len;
    // log2 of the bytes per beat
    logic [2:0]            size;
    // fixed, incr or wrap
    logic [1:0]            burst;
    logic                  lock;
    logic [3:0]            cache;
    logic [2:0]            prot;
    logic [3:0]            qos;
    logic [AXI_USER_W-1:0] user;
  } axi_ax_t;

  // write response, travels from subordinate back to manager
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    // okay, exokay, slverr or decerr
    logic [1:0]            resp;
    logic [AXI_USER_W-1:0] user;
  } axi_b_t;

endpackage

// File: rtl/axi_trace_top.sv
`timescale 1ns/1ps

module axi_trace_top
  import axi_pkg::*;
  import trace_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,

  // read address, manager to subordinate
  input  axi_ax_t    s_ar,
  input  logic       s_arvalid,
  output logic       s_arready,
  output axi_ax_t    m_ar,
  output logic       m_arvalid,
  input  logic       m_arready,

  // write address, manager to subordinate
  input  axi_ax_t    s_aw,
  input  logic       s_awvalid,
  output logic       s_awready,
  output axi_ax_t    m_aw,
  output logic       m_awvalid,
  input  logic       m_awready,

  // write response, subordinate back to manager
  input  axi_b_t     m_b,
  input  logic       m_bvalid,
  output logic       m_bready,
  output axi_b_t     s_b,
  output logic       s_bvalid,
  input  logic       s_bready,

  // trace records
  output trace_rec_t stream_tdata,
  output logic       stream_tlast,
  output logic       stream_tvalid,
  input  logic       stream_tready
);

  localparam int NUM_TAPS = 3;

  logic [TRACE_STAMP_W-1:0]  stamp;
  trace_rec_t [NUM_TAPS-1:0] tap_rec;
  logic       [NUM_TAPS-1:0] tap_valid;
  logic       [NUM_TAPS-1:0] tap_ready;

  // zero in the first cycle out of reset, wraps at its width
  always_ff @(posedge clk) begin
    if (!resetn) begin
      stamp <= '0;
    end else begin
      stamp <= stamp + 1'b1;
    end
  end

  axi_chan_tap #(
    .payload_t (axi_ax_t),
    .chan      (CH_AR)
  ) ar_tap (
    .clk         (clk),
    .resetn      (resetn),
    .stamp       (stamp),
    .src_payload (s_ar),
    .src_valid   (s_arvalid),
    .src_ready   (s_arready),
    .dst_payload (m_ar),
    .dst_valid   (m_arvalid),
    .dst_ready   (m_arready),
    .rec         (tap_rec[CH_AR]),
    .rec_valid   (tap_valid[CH_AR]),
    .rec_ready   (tap_ready[CH_AR])
  );

  axi_chan_tap #(
    .payload_t (axi_ax_t),
    .chan      (CH_AW)
  ) aw_tap (
    .clk         (clk),
    .resetn      (resetn),
    .stamp       (stamp),
    .src_payload (s_aw),
    .src_valid   (s_awvalid),
    .src_ready   (s_awready),
    .dst_payload (m_aw),
    .dst_valid   (m_awvalid),
    .dst_ready   (m_awready),
    .rec         (tap_rec[CH_AW]),
    .rec_valid   (tap_valid[CH_AW]),
    .rec_ready   (tap_ready[CH_AW])
  );

  // B runs the other way, so the subordinate side is the source here
  axi_chan_tap #(
    .payload_t (axi_b_t),
    .chan      (CH_B)
  ) b_tap (
    .clk         (clk),
    .resetn      (resetn),
    .stamp       (stamp),
    .src_payload (m_b),
    .src_valid   (m_bvalid),
    .src_ready   (m_bready),
    .dst_payload (s_b),
    .dst_valid   (s_bvalid),
    .dst_ready   (s_bready),
    .rec         (tap_rec[CH_B]),
    .rec_valid   (tap_valid[CH_B]),
    .rec_ready   (tap_ready[CH_B])
  );

  trace_arbiter #(
    .num_src (NUM_TAPS)
  ) trace_arbiter_i (
    .clk           (clk),
    .resetn        (resetn),
    .src_rec       (tap_rec),
    .src_valid     (tap_valid),
    .src_ready     (tap_ready),
    .stream_tdata  (stream_tdata),
    .stream_tlast  (stream_tlast),
    .stream_tvalid (stream_tvalid),
    .stream_tready (stream_tready)
  );

endmodule

// File: rtl/trace_arbiter.sv
`timescale 1ns/1ps

module trace_arbiter
  import trace_pkg::*;
#(
  parameter int num_src = 3
) (
  input  logic                     clk,
  input  logic                     resetn,

  // records from the taps, index is the channel code
  input  trace_rec_t [num_src-1:0] src_rec,
  input  logic       [num_src-1:0] src_valid,
  output logic       [num_src-1:0] src_ready,

  // merged trace stream
  output trace_rec_t               stream_tdata,
  output logic                     stream_tlast,
  output logic                     stream_tvalid,
  input  logic                     stream_tready
);

  localparam int IDX_W = (num_src > 1) ? $clog2(num_src) : 1;

  logic             out_valid;
  trace_rec_t       out_data;
  logic [IDX_W-1:0] last_grant;
  logic [IDX_W-1:0] grant_idx;
  logic             found;
  logic             load;

  // output slot can take a new record
  assign load = !out_valid || stream_tready;

  // search starts one past the last winner and wraps
  always_comb begin
    int cand;
    found     = 1'b0;
    grant_idx = last_grant;
    for (int i = 1; i <= num_src; i++) begin
      cand = int'(last_grant) + i;
      if (cand >= num_src) begin
        cand = cand - num_src;
      end
      if (!found && src_valid[cand]) begin
        found     = 1'b1;
        grant_idx = IDX_W'(cand);
      end
    end
  end

  // only the winner sees ready, and only when the slot loads
  always_comb begin
    src_ready = '0;
    if (load && found) begin
      src_ready[grant_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      out_valid  <= 1'b0;
      // so that the first search begins at CH_AR
      last_grant <= IDX_W'(num_src - 1);
    end else if (load) begin
      out_valid <= found;
      if (found) begin
        last_grant <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load && found) begin
      out_data <= src_rec[grant_idx];
    end
  end

  assign stream_tdata  = out_data;
  assign stream_tvalid = out_valid;
  // each record is a packet of its own
  assign stream_tlast  = 1'b1;

  // at most one tap is served, and never one without a record
  a_grant_onehot : assert property (
    @(posedge clk) disable iff (!resetn)
    $onehot0(src_ready) && ((src_ready & ~src_valid) == '0)
  ) else $error("%m: bad grant vector %b", src_ready);

  a_stream_hold : assert property (
    @(posedge clk) disable iff (!resetn)
    stream_tvalid && !stream_tready |=> stream_tvalid && $stable(stream_tdata)
  ) else $error("%m: stream beat dropped or changed under back-pressure");

endmodule

// File: rtl/trace_pkg.sv
package trace_pkg;

  import axi_pkg::*;

  // channel code carried in every record, also the tap order at the arbiter
  typedef enum logic [1:0] {
    CH_AR = 2'd0,
    CH_AW = 2'd1,
    CH_B  = 2'd2
  } trace_chan_e;

  // free-running cycle stamp, wraps silently
  localparam int TRACE_STAMP_W = 16;

  // body is sized for the widest payload, the address channel
  localparam int TRACE_BODY_W = $bits(axi_ax_t);

  // one record is one stream beat
  typedef struct packed {
    trace_chan_e              chan;
    logic [TRACE_STAMP_W-1:0] stamp;
    // narrower payloads sit in the low bits, upper bits zero
    logic [TRACE_BODY_W-1:0]  body;
  } trace_rec_t;

endpackage

// File: src.f
rtl/axi_pkg.sv
rtl/trace_pkg.sv
rtl/axi_chan_tap.sv
rtl/trace_arbiter.sv
rtl/axi_trace_top.sv
tb/tb_axi_trace_checks.sv
tb/tb_axi_trace.sv

// File: tb/tb_axi_trace.sv
`timescale 1ns/1ps

module tb_axi_trace
  import axi_pkg::*;
  import trace_pkg::*;
();

  logic        clk = 1'b0;
  logic        resetn;
  axi_ax_t     s_ar;
  logic        s_arvalid;
  logic        s_arready;
  axi_ax_t     m_ar;
  logic        m_arvalid;
  logic        m_arready;
  axi_ax_t     s_aw;
  logic        s_awvalid;
  logic        s_awready;
  axi_ax_t     m_aw;
  logic        m_awvalid;
  logic        m_awready;
  axi_b_t      m_b;
  logic        m_bvalid;
  logic        m_bready;
  axi_b_t      s_b;
  logic        s_bvalid;
  logic        s_bready;
  trace_rec_t  stream_tdata;
  logic        stream_tlast;
  logic        stream_tvalid;
  logic        stream_tready;
  logic        rr_check;
  logic        ar_hs;
  logic        aw_hs;
  logic        b_hs;
  int          mismatch_count;
  int          fault_count;
  int          hs_total;
  int          rec_total;
  int          pending;
  int          tb_mismatch_count;
  int          tb_fault_count;
  logic [31:0] rand_state = 32'h5b36;

  always #20 clk = ~clk;

  // transfers of the last rising edge, used by the drivers on the falling edge
  always @(posedge clk) begin
    ar_hs <= s_arvalid && s_arready;
    aw_hs <= s_awvalid && s_awready;
    b_hs  <= m_bvalid && m_bready;
  end

  axi_trace_top axi_trace_top_i (.*);

  tb_axi_trace_checks checks_i (.*);

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic drained();
    return !s_arvalid && !s_awvalid && !m_bvalid && pending == 0 && !stream_tvalid;
  endfunction

  // manager on AR and AW, subordinate on B
  task automatic drive_traffic(input logic new_req, input logic rand_ready);
    logic [31:0] ctl;
    logic [95:0] r;
    ctl = next_rand();
    r   = {next_rand(), next_rand(), next_rand()};
    if (ar_hs) begin
      s_arvalid = 1'b0;
    end
    if (aw_hs) begin
      s_awvalid = 1'b0;
    end
    if (b_hs) begin
      m_bvalid = 1'b0;
    end
    // payload only changes while valid is low
    if (!s_arvalid && new_req && ctl[31]) begin
      s_arvalid = 1'b1;
      s_ar      = r[$bits(axi_ax_t)-1:0];
    end
    if (!s_awvalid && new_req && ctl[30]) begin
      s_awvalid = 1'b1;
      s_aw      = r[95 -: $bits(axi_ax_t)];
    end
    if (!m_bvalid && new_req && ctl[29]) begin
      m_bvalid = 1'b1;
      m_b      = r[40 +: $bits(axi_b_t)];
    end
    m_arready = !rand_ready || ctl[28];
    m_awready = !rand_ready || ctl[27];
    s_bready  = !rand_ready || ctl[26];
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    stream_tready = 1'b1;
    while (!drained() && n < max_cycles) begin
      @(negedge clk);
      drive_traffic(1'b0, 1'b0);
      n++;
    end
    if (!drained()) begin
      tb_fault_count++;
      $display("timeout: trace stream did not drain within %0d cycles", max_cycles);
    end
  endtask

  // all three channels transfer in one cycle behind a stalled stream
  task automatic round_robin_burst();
    wait_drained(200);
    stream_tready = 1'b0;
    m_arready     = 1'b1;
    m_awready     = 1'b1;
    s_bready      = 1'b1;
    drive_traffic(1'b1, 1'b0);
    s_arvalid = 1'b1;
    s_awvalid = 1'b1;
    m_bvalid  = 1'b1;
    rr_check  = 1'b1;
    @(negedge clk);
    assert (ar_hs && aw_hs && b_hs) else begin
      tb_fault_count++;
      $display("the three channels did not transfer in the same cycle");
    end
    drive_traffic(1'b0, 1'b0);
    repeat (4) begin
      @(negedge clk);
      drive_traffic(1'b0, 1'b0);
    end
    wait_drained(50);
    rr_check = 1'b0;
  endtask

  initial begin
    resetn            = 1'b0;
    s_ar              = '0;
    s_arvalid         = 1'b0;
    m_arready         = 1'b0;
    s_aw              = '0;
    s_awvalid         = 1'b0;
    m_awready         = 1'b0;
    m_b               = '0;
    m_bvalid          = 1'b0;
    s_bready          = 1'b0;
    stream_tready     = 1'b0;
    rr_check          = 1'b0;
    tb_mismatch_count = 0;
    tb_fault_count    = 0;
    repeat (8) @(negedge clk);
    resetn = 1'b1;

    // first order after reset starts at AR
    round_robin_burst();

    // random traffic and random stream back-pressure
    repeat (300) begin
      @(negedge clk);
      drive_traffic(1'b1, 1'b1);
      stream_tready = next_rand() > 32'h4000_0000;
    end

    // long stall on the stream, the taps fill and close their channels
    stream_tready = 1'b0;
    repeat (60) begin
      @(negedge clk);
      drive_traffic(1'b1, 1'b1);
    end

    // a lone AW record leaves AW as the last channel reported
    wait_drained(200);
    m_awready = 1'b1;
    s_awvalid = 1'b1;
    @(negedge clk);
    drive_traffic(1'b0, 1'b0);

    // order resumes after the last channel reported, so B, AR, AW
    round_robin_burst();

    assert (rec_total == hs_total) else begin
      tb_mismatch_count++;
      $display("mismatch record_count expected %0d actual %0d", hs_total, rec_total);
    end
    $display("checks done: %0d handshakes, %0d records, %0d mismatches, %0d other errors",
             hs_total, rec_total, mismatch_count + tb_mismatch_count,
             fault_count + tb_fault_count);
    if (mismatch_count + tb_mismatch_count + fault_count + tb_fault_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb/tb_axi_trace_checks.sv
`timescale 1ns/1ps

module tb_axi_trace_checks
  import axi_pkg::*;
  import trace_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  // order check only during bursts with no other traffic
  input  logic       rr_check,
  input  axi_ax_t    s_ar,
  input  logic       s_arvalid,
  input  logic       s_arready,
  input  axi_ax_t    m_ar,
  input  logic       m_arvalid,
  input  logic       m_arready,
  input  axi_ax_t    s_aw,
  input  logic       s_awvalid,
  input  logic       s_awready,
  input  axi_ax_t    m_aw,
  input  logic       m_awvalid,
  input  logic       m_awready,
  input  axi_b_t     m_b,
  input  logic       m_bvalid,
  input  logic       m_bready,
  input  axi_b_t     s_b,
  input  logic       s_bvalid,
  input  logic       s_bready,
  input  trace_rec_t stream_tdata,
  input  logic       stream_tlast,
  input  logic       stream_tvalid,
  input  logic       stream_tready,
  output int         mismatch_count,
  output int         fault_count,
  output int         hs_total,
  output int         rec_total,
  output int         pending
);

  logic [TRACE_STAMP_W-1:0] model_stamp;
  logic [TRACE_BODY_W-1:0]  b_body;
  trace_chan_e              last_chan;
  // handshakes not yet seen on the stream, one queue per channel
  trace_rec_t               exp_q [3][$];

  assign b_body = {{(TRACE_BODY_W - $bits(axi_b_t)){1'b0}}, m_b};

  initial begin
    mismatch_count = 0;
    fault_count    = 0;
    hs_total       = 0;
    rec_total      = 0;
    pending        = 0;
  end

  // first busy channel after the last one reported, cyclic
  function automatic trace_chan_e next_rr(trace_chan_e last, logic [2:0] busy);
    int c;
    next_rr = last;
    for (int i = 3; i >= 1; i--) begin
      c = (int'(last) + i) % 3;
      if (busy[c]) begin
        next_rr = trace_chan_e'(c);
      end
    end
  endfunction

  always @(posedge clk) begin
    trace_rec_t  out_rec;
    trace_rec_t  ref_rec;
    trace_chan_e want;
    logic [2:0]  busy;
    if (!resetn) begin
      model_stamp <= '0;
      last_chan   <= CH_B;
      foreach (exp_q[c]) begin
        exp_q[c].delete();
      end
    end else begin
      model_stamp <= model_stamp + 1'b1;
      if (s_arvalid && s_arready) begin
        exp_q[CH_AR].push_back(trace_rec_t'{chan: CH_AR, stamp: model_stamp, body: s_ar});
        hs_total++;
      end
      if (s_awvalid && s_awready) begin
        exp_q[CH_AW].push_back(trace_rec_t'{chan: CH_AW, stamp: model_stamp, body: s_aw});
        hs_total++;
      end
      if (m_bvalid && m_bready) begin
        exp_q[CH_B].push_back(trace_rec_t'{chan: CH_B, stamp: model_stamp, body: b_body});
        hs_total++;
      end
      if (stream_tvalid && stream_tready) begin
        out_rec = stream_tdata;
        rec_total++;
        last_chan <= out_rec.chan;
        if (out_rec.chan > CH_B) begin
          fault_count++;
          $display("stream record carries an unknown channel code %0d", out_rec.chan);
        end else if (exp_q[out_rec.chan].size() == 0) begin
          fault_count++;
          $display("stream record on channel %0d has no matching handshake", out_rec.chan);
        end else begin
          if (rr_check) begin
            busy = {exp_q[2].size() != 0, exp_q[1].size() != 0, exp_q[0].size() != 0};
            want = next_rr(last_chan, busy);
            assert (out_rec.chan == want) else begin
              mismatch_count++;
              $display("mismatch round_robin expected %0d actual %0d", want, out_rec.chan);
            end
          end
          ref_rec = exp_q[out_rec.chan].pop_front();
          assert (out_rec.stamp == ref_rec.stamp) else begin
            mismatch_count++;
            $display("mismatch timestamp expected %h actual %h", ref_rec.stamp, out_rec.stamp);
          end
          assert (out_rec.body == ref_rec.body) else begin
            mismatch_count++;
            $display("mismatch record_body expected %h actual %h", ref_rec.body, out_rec.body);
          end
        end
      end
    end
    pending = exp_q[0].size() + exp_q[1].size() + exp_q[2].size();
  end

  a_pass_payload : assert property (
    @(posedge clk) disable iff (!resetn) m_ar == s_ar && m_aw == s_aw && s_b == m_b
  ) else begin
    mismatch_count++;
    $display("mismatch pass_through expected %h actual %h",
             $sampled({s_ar, s_aw, m_b}), $sampled({m_ar, m_aw, s_b}));
  end

  // source ready follows destination ready while the valid gets through
  a_pass_ready : assert property (
    @(posedge clk) disable iff (!resetn)
    (!m_arvalid || s_arready == m_arready) && (!m_awvalid || s_awready == m_awready) &&
    (!s_bvalid || m_bready == s_bready)
  ) else begin
    mismatch_count++;
    $display("mismatch pass_ready expected %b actual %b",
             $sampled({m_arready, m_awready, s_bready}),
             $sampled({s_arready, s_awready, m_bready}));
  end

  // a transfer on one side is a transfer on the other in the same cycle
  a_pass_handshake : assert property (
    @(posedge clk) disable iff (!resetn)
    {s_arvalid && s_arready, s_awvalid && s_awready, m_bvalid && m_bready} ==
    {m_arvalid && m_arready, m_awvalid && m_awready, s_bvalid && s_bready}
  ) else begin
    mismatch_count++;
    $display("mismatch pass_handshake expected %b actual %b",
             $sampled({s_arvalid && s_arready, s_awvalid && s_awready, m_bvalid && m_bready}),
             $sampled({m_arvalid && m_arready, m_awvalid && m_awready, s_bvalid && s_bready}));
  end

  a_tlast : assert property (
    @(posedge clk) disable iff (!resetn) stream_tvalid |-> stream_tlast
  ) else begin
    mismatch_count++;
    $display("mismatch stream_tlast expected 1 actual %b", $sampled(stream_tlast));
  end

  // a capture taken while the stream is stalled must close the channel
  a_stall : assert property (
    @(posedge clk) disable iff (!resetn)
    ((stream_tvalid && !stream_tready && s_arvalid && s_arready) ##1 !stream_tready
      |-> !s_arready) and
    ((stream_tvalid && !stream_tready && s_awvalid && s_awready) ##1 !stream_tready
      |-> !s_awready) and
    ((stream_tvalid && !stream_tready && m_bvalid && m_bready) ##1 !stream_tready
      |-> !m_bready)
  ) else begin
    fault_count++;
    $display("a source ready stayed high while its tap buffer was full");
  end

  a_reset_idle : assert property (
    @(negedge clk) !resetn |-> !stream_tvalid && !m_arvalid && !m_awvalid && !s_bvalid
  ) else begin
    fault_count++;
    $display("a valid output was high during reset");
  end

endmodule
